// File: logic/copy_engine_pkg.sv
package copy_engine_pkg;

   localparam int WORD_W = 32;
   localparam int REM_W  = 4;

   // valid bytes are the upper ones
   localparam logic [REM_W-1:0] REM_FULL = 4'b0000;
   localparam logic [REM_W-1:0] REM_3B   = 4'b0001;
   localparam logic [REM_W-1:0] REM_2B   = 4'b0011;
   localparam logic [REM_W-1:0] REM_1B   = 4'b0111;

   // header and trailer layout
   localparam int HDR_WORDS = 8;
   localparam int CTRL_IDX  = 4;
   localparam int LEN_IDX   = 5;
   localparam int TASK_IDX  = 6;
   localparam int TASK_W    = 10;

   localparam int FIFO_DEPTH = 16;
   localparam int CNT_W      = 16;

   localparam int DCR_ADDR_W = 10;
   localparam logic [DCR_ADDR_W-1:0] DCR_TASK_ADDR  = 10'h000;
   localparam logic [DCR_ADDR_W-1:0] DCR_COUNT_ADDR = 10'h001;

   // parser states
   localparam logic [2:0] PS_IDLE       = 3'd0;
   localparam logic [2:0] PS_HEADER     = 3'd1;
   localparam logic [2:0] PS_PAYLOAD    = 3'd2;
   localparam logic [2:0] PS_TRAIL_WAIT = 3'd3;
   localparam logic [2:0] PS_HANDOFF    = 3'd4;

   // writer states
   localparam logic [1:0] WS_STREAM  = 2'd0;
   localparam logic [1:0] WS_TRAILER = 2'd1;
   localparam logic [1:0] WS_EOF     = 2'd2;
   localparam logic [1:0] WS_ACK     = 2'd3;

   // inbound control word and outbound completion word share this layout
   typedef union packed {
      logic [WORD_W-1:0] raw;
      struct packed {
         logic        op_comp;
         logic        op_decomp;
         logic        op_copy;
         logic        status;
         logic [27:0] rsvd;
      } f;
   } ctrl_word_u;

endpackage

// File: logic/descriptor_parser.sv
`timescale 1ns/10ps

module descriptor_parser (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [copy_engine_pkg::WORD_W-1:0] in_data_i,
   input  logic [copy_engine_pkg::REM_W-1:0]  in_rem_i,
   input  logic                               in_sof_n_i,
   input  logic                               in_eof_n_i,
   input  logic                               in_eop_n_i,
   input  logic                               in_src_rdy_n_i,
   output logic                               in_dst_rdy_n_o,
   input  logic                               full_i,
   output logic                               push_o,
   output logic [copy_engine_pkg::WORD_W-1:0] wdata_o,
   output logic [copy_engine_pkg::REM_W-1:0]  wrem_o,
   output logic                               wlast_o,
   input  logic                               done_ack_i,
   output logic                               done_req_o,
   output copy_engine_pkg::ctrl_word_u        done_ctrl_o,
   output logic [copy_engine_pkg::WORD_W-1:0] done_bytes_o,
   output logic [copy_engine_pkg::TASK_W-1:0] done_task_o
);
   import copy_engine_pkg::*;

   logic [2:0]        state_q;
   logic [2:0]        hdr_cnt_q;
   logic              run_q;
   ctrl_word_u        ctrl_q;
   logic [WORD_W-1:0] len_q;
   logic [WORD_W-1:0] byte_cnt_q;
   logic [TASK_W-1:0] task_q;
   logic              accept;
   logic              in_xfer;
   logic              in_last;
   logic [WORD_W-1:0] keep;
   logic [2:0]        word_bytes;

   // only a kept payload waits for buffer space
   always_comb begin
      case (state_q)
         PS_IDLE, PS_HEADER: accept = run_q;
         PS_PAYLOAD:         accept = run_q && !(ctrl_q.f.op_copy && full_i);
         default:            accept = 1'b0;
      endcase
   end

   assign in_dst_rdy_n_o = !accept;
   assign in_xfer        = accept && !in_src_rdy_n_i;
   assign in_last        = !in_eof_n_i;

   // tail mask and byte count of the current word
   always_comb begin
      keep       = '1;
      word_bytes = 3'd4;
      if (!in_eop_n_i) begin
         case (in_rem_i)
            REM_3B: begin
               keep       = {WORD_W{1'b1}} << 8;
               word_bytes = 3'd3;
            end
            REM_2B: begin
               keep       = {WORD_W{1'b1}} << 16;
               word_bytes = 3'd2;
            end
            REM_1B: begin
               keep       = {WORD_W{1'b1}} << 24;
               word_bytes = 3'd1;
            end
            default: ;
         endcase
      end
   end

   assign push_o  = in_xfer && (state_q == PS_PAYLOAD) && ctrl_q.f.op_copy;
   assign wdata_o = in_data_i & keep;
   assign wrem_o  = in_eop_n_i ? REM_FULL : in_rem_i;
   assign wlast_o = !in_eop_n_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q    <= PS_IDLE;
         hdr_cnt_q  <= '0;
         run_q      <= 1'b0;
         byte_cnt_q <= '0;
         ctrl_q     <= '0;
      end else begin
         run_q <= 1'b1;
         case (state_q)
            PS_IDLE: begin
               // anything before sof is dropped
               if (in_xfer && !in_sof_n_i) begin
                  hdr_cnt_q  <= 3'd1;
                  byte_cnt_q <= '0;
                  state_q    <= in_last ? PS_TRAIL_WAIT : PS_HEADER;
               end
            end
            PS_HEADER: begin
               if (in_xfer) begin
                  hdr_cnt_q <= hdr_cnt_q + 3'd1;
                  if (hdr_cnt_q == 3'(CTRL_IDX))
                     ctrl_q.raw <= in_data_i;
                  if (in_last)
                     state_q <= PS_TRAIL_WAIT;
                  else if (hdr_cnt_q == 3'(HDR_WORDS - 1))
                     state_q <= PS_PAYLOAD;
               end
            end
            PS_PAYLOAD: begin
               if (in_xfer) begin
                  byte_cnt_q <= byte_cnt_q + WORD_W'(word_bytes);
                  if (in_last)
                     state_q <= PS_TRAIL_WAIT;
               end
            end
            PS_TRAIL_WAIT: begin
               if (done_ack_i)
                  state_q <= PS_HANDOFF;
            end
            PS_HANDOFF: begin
               if (!done_ack_i)
                  state_q <= PS_IDLE;
            end
            default: state_q <= PS_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (in_xfer && state_q == PS_HEADER) begin
         if (hdr_cnt_q == 3'(LEN_IDX))
            len_q <= in_data_i;
         if (hdr_cnt_q == 3'(TASK_IDX))
            task_q <= in_data_i[TASK_W-1:0];
      end
   end

   // fields hold still until the writer acknowledges
   assign done_req_o   = (state_q == PS_TRAIL_WAIT);
   assign done_bytes_o = byte_cnt_q;
   assign done_task_o  = task_q;

   always_comb begin
      done_ctrl_o          = ctrl_q;
      done_ctrl_o.f.status = ctrl_q.f.op_copy && (byte_cnt_q == len_q);
   end

endmodule

// File: logic/payload_fifo.sv
`timescale 1ns/10ps

module payload_fifo (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               push_i,
   input  logic [copy_engine_pkg::WORD_W-1:0] wdata_i,
   input  logic [copy_engine_pkg::REM_W-1:0]  wrem_i,
   input  logic                               wlast_i,
   input  logic                               pop_i,
   output logic                               full_o,
   output logic                               empty_o,
   output logic [copy_engine_pkg::WORD_W-1:0] rdata_o,
   output logic [copy_engine_pkg::REM_W-1:0]  rrem_o,
   output logic                               rlast_o
);
   import copy_engine_pkg::*;

   logic [WORD_W-1:0]             data_mem [FIFO_DEPTH];
   logic [REM_W-1:0]              rem_mem  [FIFO_DEPTH];
   logic                          last_mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
   logic [$clog2(FIFO_DEPTH):0]   count_q;
   logic                          do_push;
   logic                          do_pop;

   assign full_o  = (count_q == ($clog2(FIFO_DEPTH) + 1)'(FIFO_DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   // head entry read straight out of the array
   assign rdata_o = data_mem[rd_ptr_q];
   assign rrem_o  = rem_mem[rd_ptr_q];
   assign rlast_o = last_mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (do_push) begin
         data_mem[wr_ptr_q] <= wdata_i;
         rem_mem[wr_ptr_q]  <= wrem_i;
         last_mem[wr_ptr_q] <= wlast_i;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_push && !do_pop)
            count_q <= count_q + 1'b1;
         else if (do_pop && !do_push)
            count_q <= count_q - 1'b1;
      end
   end

endmodule

// File: logic/completion_writer.sv
`timescale 1ns/10ps

module completion_writer (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               out_dst_rdy_n_i,
   output logic [copy_engine_pkg::WORD_W-1:0] out_data_o,
   output logic [copy_engine_pkg::REM_W-1:0]  out_rem_o,
   output logic                               out_sof_n_o,
   output logic                               out_eof_n_o,
   output logic                               out_sop_n_o,
   output logic                               out_eop_n_o,
   output logic                               out_src_rdy_n_o,
   input  logic                               empty_i,
   input  logic [copy_engine_pkg::WORD_W-1:0] rdata_i,
   input  logic [copy_engine_pkg::REM_W-1:0]  rrem_i,
   input  logic                               rlast_i,
   output logic                               pop_o,
   input  logic                               done_req_i,
   input  copy_engine_pkg::ctrl_word_u        done_ctrl_i,
   input  logic [copy_engine_pkg::WORD_W-1:0] done_bytes_i,
   input  logic [copy_engine_pkg::TASK_W-1:0] done_task_i,
   output logic                               done_ack_o,
   output logic                               frame_done_o
);
   import copy_engine_pkg::*;

   logic [1:0]        state_q;
   logic [2:0]        tr_cnt_q;
   logic              sof_pend_q;
   logic              sop_pend_q;
   logic              out_xfer;
   logic              can_load;
   logic              load_fifo;
   logic              load_trl;
   ctrl_word_u        cpl;
   logic [WORD_W-1:0] trl_data;

   // output register is free when empty or draining this cycle
   assign out_xfer  = !out_src_rdy_n_o && !out_dst_rdy_n_i;
   assign can_load  = out_src_rdy_n_o || !out_dst_rdy_n_i;
   assign load_fifo = can_load && (state_q == WS_STREAM) && !empty_i;
   assign load_trl  = can_load && ((state_q == WS_TRAILER) ||
                      (state_q == WS_STREAM && empty_i && done_req_i));

   assign pop_o        = load_fifo;
   assign frame_done_o = out_xfer && !out_eof_n_o;
   assign done_ack_o   = (state_q == WS_ACK);

   always_comb begin
      cpl.raw         = '0;
      cpl.f.op_comp   = done_ctrl_i.f.op_comp;
      cpl.f.op_decomp = done_ctrl_i.f.op_decomp;
      cpl.f.op_copy   = done_ctrl_i.f.op_copy;
      cpl.f.status    = done_ctrl_i.f.status;
      case (int'(tr_cnt_q))
         CTRL_IDX: trl_data = cpl.raw;
         LEN_IDX:  trl_data = done_bytes_i;
         TASK_IDX: trl_data = WORD_W'(done_task_i);
         default:  trl_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (load_fifo)
         out_data_o <= rdata_i;
      else if (load_trl)
         out_data_o <= trl_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q         <= WS_STREAM;
         tr_cnt_q        <= '0;
         sof_pend_q      <= 1'b1;
         sop_pend_q      <= 1'b1;
         out_src_rdy_n_o <= 1'b1;
         out_sof_n_o     <= 1'b1;
         out_eof_n_o     <= 1'b1;
         out_sop_n_o     <= 1'b1;
         out_eop_n_o     <= 1'b1;
         out_rem_o       <= REM_FULL;
      end else begin
         if (load_fifo) begin
            out_src_rdy_n_o <= 1'b0;
            out_sof_n_o     <= !sof_pend_q;
            out_sop_n_o     <= !sop_pend_q;
            out_eop_n_o     <= !rlast_i;
            out_eof_n_o     <= 1'b1;
            out_rem_o       <= rrem_i;
            sof_pend_q      <= 1'b0;
            sop_pend_q      <= 1'b0;
         end else if (load_trl) begin
            out_src_rdy_n_o <= 1'b0;
            out_sof_n_o     <= !sof_pend_q;
            out_sop_n_o     <= 1'b1;
            out_eop_n_o     <= 1'b1;
            out_eof_n_o     <= (tr_cnt_q != 3'(HDR_WORDS - 1));
            out_rem_o       <= REM_FULL;
            sof_pend_q      <= 1'b0;
            tr_cnt_q        <= tr_cnt_q + 3'd1;
         end else if (out_xfer) begin
            out_src_rdy_n_o <= 1'b1;
            out_sof_n_o     <= 1'b1;
            out_eof_n_o     <= 1'b1;
            out_sop_n_o     <= 1'b1;
            out_eop_n_o     <= 1'b1;
         end
         case (state_q)
            WS_STREAM: begin
               if (load_trl)
                  state_q <= WS_TRAILER;
            end
            WS_TRAILER: begin
               if (load_trl && tr_cnt_q == 3'(HDR_WORDS - 1))
                  state_q <= WS_EOF;
            end
            WS_EOF: begin
               // trailer word 7 accepted, arm flags for the next frame
               if (frame_done_o) begin
                  state_q    <= WS_ACK;
                  sof_pend_q <= 1'b1;
                  sop_pend_q <= 1'b1;
               end
            end
            default: begin
               if (!done_req_i)
                  state_q <= WS_STREAM;
            end
         endcase
      end
   end

endmodule

// File: logic/dcr_status_regs.sv
`timescale 1ns/10ps

module dcr_status_regs (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic [copy_engine_pkg::DCR_ADDR_W-1:0] dcr_abus_i,
   input  logic                                   dcr_read_i,
   input  logic                                   dcr_write_i,
   output logic                                   dcr_ack_o,
   output logic [copy_engine_pkg::WORD_W-1:0]     dcr_dbus_o,
   input  logic                                   frame_done_i,
   input  logic [copy_engine_pkg::TASK_W-1:0]     done_task_i,
   output logic                                   soft_rst_o
);
   import copy_engine_pkg::*;

   logic [CNT_W-1:0]  count_q;
   logic [TASK_W-1:0] task_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dcr_ack_o  <= 1'b0;
         soft_rst_o <= 1'b0;
         count_q    <= '0;
         task_q     <= '0;
      end else begin
         dcr_ack_o <= dcr_read_i || dcr_write_i;
         // pulse ends itself, the engine reset clears this flop too
         soft_rst_o <= dcr_write_i && dcr_ack_o;
         if (frame_done_i) begin
            count_q <= count_q + 1'b1;
            task_q  <= done_task_i;
         end
      end
   end

   // readback follows the address bus
   always_comb begin
      case (dcr_abus_i)
         DCR_TASK_ADDR:  dcr_dbus_o = WORD_W'(task_q);
         DCR_COUNT_ADDR: dcr_dbus_o = WORD_W'(count_q);
         default:        dcr_dbus_o = '0;
      endcase
   end

endmodule

// File: logic/copy_engine_top.sv
`timescale 1ns/10ps

module copy_engine_top (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic [copy_engine_pkg::WORD_W-1:0]     in_data_i,
   input  logic [copy_engine_pkg::REM_W-1:0]      in_rem_i,
   input  logic                                   in_sof_n_i,
   input  logic                                   in_eof_n_i,
   input  logic                                   in_sop_n_i,
   input  logic                                   in_eop_n_i,
   input  logic                                   in_src_rdy_n_i,
   output logic                                   in_dst_rdy_n_o,
   output logic [copy_engine_pkg::WORD_W-1:0]     out_data_o,
   output logic [copy_engine_pkg::REM_W-1:0]      out_rem_o,
   output logic                                   out_sof_n_o,
   output logic                                   out_eof_n_o,
   output logic                                   out_sop_n_o,
   output logic                                   out_eop_n_o,
   output logic                                   out_src_rdy_n_o,
   input  logic                                   out_dst_rdy_n_i,
   input  logic [copy_engine_pkg::DCR_ADDR_W-1:0] dcr_abus_i,
   input  logic                                   dcr_read_i,
   input  logic                                   dcr_write_i,
   output logic                                   dcr_ack_o,
   output logic [copy_engine_pkg::WORD_W-1:0]     dcr_dbus_o
);
   import copy_engine_pkg::*;

   logic              eng_rst_n;
   logic              soft_rst;
   logic              fifo_push;
   logic              fifo_pop;
   logic              fifo_full;
   logic              fifo_empty;
   logic [WORD_W-1:0] fifo_wdata;
   logic [WORD_W-1:0] fifo_rdata;
   logic [REM_W-1:0]  fifo_wrem;
   logic [REM_W-1:0]  fifo_rrem;
   logic              fifo_wlast;
   logic              fifo_rlast;
   logic              done_req;
   logic              done_ack;
   logic              frame_done;
   ctrl_word_u        done_ctrl;
   logic [WORD_W-1:0] done_bytes;
   logic [TASK_W-1:0] done_task;

   // a register write restarts the whole engine, counter included
   assign eng_rst_n = rst_n && !soft_rst;

   // payload start is known from the header count, in_sop_n_i is not needed
   descriptor_parser u_parser (
      .clk            (clk),
      .rst_n          (eng_rst_n),
      .in_data_i      (in_data_i),
      .in_rem_i       (in_rem_i),
      .in_sof_n_i     (in_sof_n_i),
      .in_eof_n_i     (in_eof_n_i),
      .in_eop_n_i     (in_eop_n_i),
      .in_src_rdy_n_i (in_src_rdy_n_i),
      .in_dst_rdy_n_o (in_dst_rdy_n_o),
      .full_i         (fifo_full),
      .push_o         (fifo_push),
      .wdata_o        (fifo_wdata),
      .wrem_o         (fifo_wrem),
      .wlast_o        (fifo_wlast),
      .done_ack_i     (done_ack),
      .done_req_o     (done_req),
      .done_ctrl_o    (done_ctrl),
      .done_bytes_o   (done_bytes),
      .done_task_o    (done_task)
   );

   payload_fifo u_fifo (
      .clk     (clk),
      .rst_n   (eng_rst_n),
      .push_i  (fifo_push),
      .wdata_i (fifo_wdata),
      .wrem_i  (fifo_wrem),
      .wlast_i (fifo_wlast),
      .pop_i   (fifo_pop),
      .full_o  (fifo_full),
      .empty_o (fifo_empty),
      .rdata_o (fifo_rdata),
      .rrem_o  (fifo_rrem),
      .rlast_o (fifo_rlast)
   );

   completion_writer u_writer (
      .clk             (clk),
      .rst_n           (eng_rst_n),
      .out_dst_rdy_n_i (out_dst_rdy_n_i),
      .out_data_o      (out_data_o),
      .out_rem_o       (out_rem_o),
      .out_sof_n_o     (out_sof_n_o),
      .out_eof_n_o     (out_eof_n_o),
      .out_sop_n_o     (out_sop_n_o),
      .out_eop_n_o     (out_eop_n_o),
      .out_src_rdy_n_o (out_src_rdy_n_o),
      .empty_i         (fifo_empty),
      .rdata_i         (fifo_rdata),
      .rrem_i          (fifo_rrem),
      .rlast_i         (fifo_rlast),
      .pop_o           (fifo_pop),
      .done_req_i      (done_req),
      .done_ctrl_i     (done_ctrl),
      .done_bytes_i    (done_bytes),
      .done_task_i     (done_task),
      .done_ack_o      (done_ack),
      .frame_done_o    (frame_done)
   );

   dcr_status_regs u_regs (
      .clk          (clk),
      .rst_n        (eng_rst_n),
      .dcr_abus_i   (dcr_abus_i),
      .dcr_read_i   (dcr_read_i),
      .dcr_write_i  (dcr_write_i),
      .dcr_ack_o    (dcr_ack_o),
      .dcr_dbus_o   (dcr_dbus_o),
      .frame_done_i (frame_done),
      .done_task_i  (done_task),
      .soft_rst_o   (soft_rst)
   );

endmodule

// File: testbench/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// words as {data, rem, sof_n, eof_n, sop_n, eop_n}
logic [39:0]       stim_q[$];
logic [39:0]       exp_q[$];
logic [31:0]       stim_seed;
int                exp_count;
logic [TASK_W-1:0] exp_task;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// upper half of the state is the better random source
function automatic int unsigned pick_below(input int unsigned n);
   stim_seed = lcg_next(stim_seed);
   return (stim_seed >> 16) % n;
endfunction

function automatic logic [31:0] rand_word();
   return {16'(pick_below(65536)), 16'(pick_below(65536))};
endfunction

// upper bytes stay valid, the rest read as zero
function automatic logic [31:0] tail_mask(input logic [REM_W-1:0] rem);
   case (rem)
      REM_3B:  return 32'hffff_ff00;
      REM_2B:  return 32'hffff_0000;
      REM_1B:  return 32'hff00_0000;
      default: return 32'hffff_ffff;
   endcase
endfunction

task automatic build_frame();
   int                n_words;
   logic [REM_W-1:0]  last_rem;
   logic [REM_W-1:0]  rem;
   logic [2:0]        ops;
   logic [TASK_W-1:0] task_id;
   logic [31:0]       bytes;
   logic [31:0]       len;
   logic [31:0]       word;
   logic              status;
   logic              last;
   n_words = 1 + int'(pick_below(40));
   case (pick_below(4))
      0:       last_rem = REM_3B;
      1:       last_rem = REM_2B;
      2:       last_rem = REM_1B;
      default: last_rem = REM_FULL;
   endcase
   // ops is {comp, decomp, copy}
   ops     = 3'(pick_below(8));
   task_id = TASK_W'(pick_below(1024));
   bytes   = 32'((n_words - 1) * 4 + $countones(tail_mask(last_rem)) / 8);
   len     = (pick_below(4) == 0) ? bytes + 32'(1 + pick_below(7)) : bytes;
   status  = ops[0] && (len == bytes);
   for (int i = 0; i < HDR_WORDS; i++) begin
      word = rand_word();
      if (i == CTRL_IDX)
         word[31:29] = ops;
      if (i == LEN_IDX)
         word = len;
      if (i == TASK_IDX)
         word[TASK_W-1:0] = task_id;
      stim_q.push_back({word, REM_FULL, i != 0, 1'b1, 1'b1, 1'b1});
   end
   for (int i = 0; i < n_words; i++) begin
      last = (i == n_words - 1);
      rem  = last ? last_rem : REM_FULL;
      word = rand_word();
      stim_q.push_back({word, rem, 1'b1, !last, i != 0, !last});
      if (ops[0])
         exp_q.push_back({word & tail_mask(rem), rem, i != 0, 1'b1, i != 0, !last});
   end
   for (int i = 0; i < HDR_WORDS; i++) begin
      case (i)
         CTRL_IDX: word = {ops, status, 28'h0};
         LEN_IDX:  word = bytes;
         TASK_IDX: word = 32'(task_id);
         default:  word = '0;
      endcase
      exp_q.push_back({word, REM_FULL, ops[0] || i != 0, i != HDR_WORDS - 1, 1'b1, 1'b1});
   end
   exp_count++;
   exp_task = task_id;
endtask

`endif

// File: testbench/copy_engine_tb.sv
`timescale 1ns/10ps

module copy_engine_tb;
   import copy_engine_pkg::*;

   localparam int          NUM_FRAMES = 60;
   localparam logic [31:0] SEED       = 32'hca64_f5e1;

   logic                  clk;
   logic                  rst_n;
   logic [WORD_W-1:0]     in_data_i;
   logic [REM_W-1:0]      in_rem_i;
   logic                  in_sof_n_i;
   logic                  in_eof_n_i;
   logic                  in_sop_n_i;
   logic                  in_eop_n_i;
   logic                  in_src_rdy_n_i;
   logic                  in_dst_rdy_n_o;
   logic [WORD_W-1:0]     out_data_o;
   logic [REM_W-1:0]      out_rem_o;
   logic                  out_sof_n_o;
   logic                  out_eof_n_o;
   logic                  out_sop_n_o;
   logic                  out_eop_n_o;
   logic                  out_src_rdy_n_o;
   logic                  out_dst_rdy_n_i;
   logic [DCR_ADDR_W-1:0] dcr_abus_i;
   logic                  dcr_read_i;
   logic                  dcr_write_i;
   logic                  dcr_ack_o;
   logic [WORD_W-1:0]     dcr_dbus_o;
   logic [31:0]           bp_seed;
   int                    stall;
   int                    frames_done;

   `include "tb_frame_model.svh"

   copy_engine_top dut (.*);

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
      assert (got === want)
      else report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, want));
   endtask

   task automatic check_output();
      logic [39:0] want;
      assert (exp_q.size() != 0) else report_failure("outbound word arrived with none expected");
      want = exp_q.pop_front();
      check_value("out_data_o", out_data_o, want[39:8]);
      check_value("out_rem_o", 32'(out_rem_o), 32'(want[7:4]));
      check_value("out_sof_n_o", 32'(out_sof_n_o), 32'(want[3]));
      check_value("out_eof_n_o", 32'(out_eof_n_o), 32'(want[2]));
      check_value("out_sop_n_o", 32'(out_sop_n_o), 32'(want[1]));
      check_value("out_eop_n_o", 32'(out_eop_n_o), 32'(want[0]));
      if (!out_eof_n_o)
         frames_done++;
   endtask

   // each word is held until the edge where both readies are low
   task automatic send_frame();
      logic [39:0] w;
      while (stim_q.size() > 0) begin
         w = stim_q.pop_front();
         if (pick_below(8) == 0) begin
            in_src_rdy_n_i <= 1'b1;
            repeat (1 + pick_below(3)) @(posedge clk);
         end
         {in_data_i, in_rem_i, in_sof_n_i, in_eof_n_i, in_sop_n_i, in_eop_n_i} <= w;
         in_src_rdy_n_i <= 1'b0;
         do @(posedge clk); while (in_dst_rdy_n_o);
      end
      in_src_rdy_n_i <= 1'b1;
   endtask

   task automatic dcr_access(input logic wr, input logic [DCR_ADDR_W-1:0] addr,
                             input logic [31:0] want, input string name);
      dcr_abus_i  <= addr;
      dcr_read_i  <= !wr;
      dcr_write_i <= wr;
      @(posedge clk);
      assert (!dcr_ack_o) else report_failure("dcr_ack_o was high before the request was seen");
      @(posedge clk);
      assert (dcr_ack_o) else report_failure("dcr_ack_o did not rise one cycle after the request");
      if (!wr)
         check_value(name, dcr_dbus_o, want);
      dcr_read_i  <= 1'b0;
      dcr_write_i <= 1'b0;
      do @(posedge clk); while (dcr_ack_o);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // outbound ready with short gaps and stalls longer than the FIFO
   initial begin
      bp_seed = SEED;
      stall   = 0;
      out_dst_rdy_n_i <= 1'b1;
      forever begin
         @(posedge clk);
         bp_seed = lcg_next(bp_seed);
         if (stall > 0)
            stall--;
         else if (bp_seed[31:26] == 6'd0)
            stall = FIFO_DEPTH + 1 + int'(bp_seed[19:16]);
         out_dst_rdy_n_i <= (stall > 0) || (bp_seed[25:23] == 3'd0);
      end
   end

   initial begin
      frames_done = 0;
      forever begin
         @(posedge clk);
         if (!out_src_rdy_n_o && !out_dst_rdy_n_i)
            check_output();
      end
   end

   initial begin
      repeat (NUM_FRAMES * 200) @(posedge clk);
      report_failure("watchdog expired before all frames completed");
   end

   initial begin
      rst_n          <= 1'b0;
      in_data_i      <= '0;
      in_rem_i       <= REM_FULL;
      in_sof_n_i     <= 1'b1;
      in_eof_n_i     <= 1'b1;
      in_sop_n_i     <= 1'b1;
      in_eop_n_i     <= 1'b1;
      in_src_rdy_n_i <= 1'b1;
      dcr_abus_i     <= '0;
      dcr_read_i     <= 1'b0;
      dcr_write_i    <= 1'b0;
      stim_seed = SEED;
      exp_count = 0;
      exp_task  = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      check_value("out_src_rdy_n_o", 32'(out_src_rdy_n_o), 32'd1);
      check_value("out_sof_n_o", 32'(out_sof_n_o), 32'd1);
      check_value("out_eof_n_o", 32'(out_eof_n_o), 32'd1);
      check_value("out_sop_n_o", 32'(out_sop_n_o), 32'd1);
      check_value("out_eop_n_o", 32'(out_eop_n_o), 32'd1);
      check_value("in_dst_rdy_n_o", 32'(in_dst_rdy_n_o), 32'd1);
      check_value("dcr_ack_o", 32'(dcr_ack_o), 32'd0);
      // inbound ready comes up one cycle after reset
      repeat (2) @(posedge clk);
      check_value("in_dst_rdy_n_o", 32'(in_dst_rdy_n_o), 32'd0);
      dcr_access(1'b0, DCR_COUNT_ADDR, 32'(exp_count), "dcr_dbus_o (count)");
      for (int f = 1; f <= NUM_FRAMES; f++) begin
         build_frame();
         send_frame();
         while (frames_done < f)
            @(posedge clk);
         dcr_access(1'b0, DCR_COUNT_ADDR, 32'(exp_count), "dcr_dbus_o (count)");
         dcr_access(1'b0, DCR_TASK_ADDR, 32'(exp_task), "dcr_dbus_o (task)");
         // engine is idle here, so a write only clears the status
         if (f == NUM_FRAMES / 2) begin
            dcr_access(1'b1, DCR_ADDR_W'(pick_below(1024)), '0, "");
            exp_count = 0;
            exp_task  = '0;
            dcr_access(1'b0, DCR_COUNT_ADDR, 32'(exp_count), "dcr_dbus_o (count)");
         end
      end
      assert (exp_q.size() == 0) else report_failure("expected outbound words never arrived");
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: sources.f
+incdir+testbench
logic/copy_engine_pkg.sv
logic/descriptor_parser.sv
logic/payload_fifo.sv
logic/completion_writer.sv
logic/dcr_status_regs.sv
logic/copy_engine_top.sv
testbench/copy_engine_tb.sv

// File: Makefile
# Verilator build and run for the copy engine testbench

VERILATOR ?= verilator
TOP       ?= copy_engine_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
